/* sources.f */
rtl/soc_pkg.sv
rtl/mem_select.sv
rtl/word_ram.sv
rtl/uart.sv
rtl/rgb_enc.sv
rtl/hexdisp.sv
rtl/soc.sv
tests/tb_clock.sv
tests/soc_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module soc_tb -f sources.f -o soc_sim
./obj_dir/soc_sim > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

/* tests/soc_tb.sv */
module soc_tb
  import soc_pkg::*;
();

  localparam logic [31:0] enc_base = 32'h0010_0000;
  localparam logic [31:0] serial0_base = 32'h0010_0010;
  localparam logic [31:0] serial1_base = 32'h0010_0020;
  localparam logic [31:0] switch_addr = 32'h0010_0030;
  // Six UART bytes plus RAM accesses and encoder steps with a margin of four
  localparam int watchdog_cycles = (6 * 10 * 8 + 64 * 4 + 40 * 10) * 4;

  logic        clock_50;
  logic        rst;
  bus_req_t    bus_req;
  logic [9:0]  sw;
  logic [1:0]  quad;
  logic        pb;
  logic        serial0_tx;
  logic        serial1_tx;
  logic        serial0_rx;
  logic        serial1_rx;
  logic [15:0] rdata;
  logic [2:0]  rgb;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;

  // Expected response that travels with each request
  logic        cur_chk;
  logic [15:0] cur_exp;
  string       cur_name;
  logic        chk_a;
  logic [15:0] exp_a;
  string       name_a;
  logic [15:0] last_ref;
  logic        checking;

  int          errors;
  integer      seed;
  logic [31:0] rnd;
  logic [15:0] ram_model [64];
  logic [5:0]  idx;
  logic [5:0]  other;
  logic [15:0] word;
  logic [1:0]  q_model;
  logic [4:0]  pos_model;

  tb_clock clk_gen (.clock_50(clock_50));

  soc #(.clks_per_bit(8), .ram_words(1024)) soc_inst (
    .clock_50(clock_50),
    .rst(rst),
    .bus_req(bus_req),
    .sw(sw),
    .quad(quad),
    .pb(pb),
    .serial0_rx(serial0_rx),
    .serial1_rx(serial1_rx),
    .rdata(rdata),
    .rgb(rgb),
    .serial0_tx(serial0_tx),
    .serial1_tx(serial1_tx),
    .hex0(hex0),
    .hex1(hex1),
    .hex2(hex2),
    .hex3(hex3)
  );

  // Both UARTs in loopback
  assign serial0_rx = serial0_tx;
  assign serial1_rx = serial1_tx;

  function automatic logic [6:0] seg_ref(input logic [3:0] d);
    case (d)
      4'h0: seg_ref = 7'b1000000;
      4'h1: seg_ref = 7'b1111001;
      4'h2: seg_ref = 7'b0100100;
      4'h3: seg_ref = 7'b0110000;
      4'h4: seg_ref = 7'b0011001;
      4'h5: seg_ref = 7'b0010010;
      4'h6: seg_ref = 7'b0000010;
      4'h7: seg_ref = 7'b1111000;
      4'h8: seg_ref = 7'b0000000;
      4'h9: seg_ref = 7'b0010000;
      4'ha: seg_ref = 7'b0001000;
      4'hb: seg_ref = 7'b0000011;
      4'hc: seg_ref = 7'b1000110;
      4'hd: seg_ref = 7'b0100001;
      4'he: seg_ref = 7'b0000110;
      default: seg_ref = 7'b0001110;
    endcase
  endfunction

  function automatic logic [27:0] segs_of(input logic [15:0] w);
    segs_of = {seg_ref(w[15:12]), seg_ref(w[11:8]), seg_ref(w[7:4]), seg_ref(w[3:0])};
  endfunction

  // Word after a write with only one lane for a byte write
  function automatic logic [15:0] ram_merge(input logic [15:0] old, input logic bc,
                                            input logic hi, input logic [15:0] wd);
    if (!bc) ram_merge = wd;
    else if (hi) ram_merge = {wd[15:8], old[7:0]};
    else ram_merge = {old[15:8], wd[7:0]};
  endfunction

  function automatic logic [1:0] gray_next(input logic [1:0] q, input logic up);
    case (q)
      2'b00: gray_next = up ? 2'b01 : 2'b10;
      2'b01: gray_next = up ? 2'b11 : 2'b00;
      2'b11: gray_next = up ? 2'b10 : 2'b01;
      default: gray_next = up ? 2'b00 : 2'b11;
    endcase
  endfunction

  function automatic logic [4:0] pos_next(input logic [4:0] p, input logic up);
    if (up) pos_next = (p == 5'd23) ? 5'd0 : p + 5'd1;
    else pos_next = (p == 5'd0) ? 5'd23 : p - 5'd1;
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      errors = errors + 1;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic drive_req(input logic wr, input logic bc, input logic [31:0] addr,
                           input logic [15:0] wd, input logic chk, input logic [15:0] exp,
                           input string name);
    bus_req_t req;
    req = '{valid: 1'b1, write: wr, bytectl: bc, addr: addr, wdata: wd};
    @(posedge clock_50);
    bus_req <= req;
    cur_chk <= chk;
    cur_exp <= exp;
    cur_name <= name;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [15:0] wd, input string name);
    drive_req(1'b1, 1'b0, addr, wd, 1'b1, 16'h0000, name);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [15:0] exp,
                             input string name);
    drive_req(1'b0, 1'b0, addr, 16'h0000, 1'b1, exp, name);
  endtask

  task automatic go_idle();
    @(posedge clock_50);
    bus_req <= '0;
    cur_chk <= 1'b1;
    cur_exp <= 16'h0000;
    cur_name <= "idle";
  endtask

  task automatic read_value(input logic [31:0] addr, output logic [15:0] value);
    drive_req(1'b0, 1'b0, addr, 16'h0000, 1'b0, 16'h0000, "capture");
    go_idle();
    @(negedge clock_50);
    value = rdata;
  endtask

  task automatic quad_step(input logic up);
    q_model = gray_next(q_model, up);
    pos_model = pos_next(pos_model, up);
    @(posedge clock_50);
    quad <= q_model;
    repeat (6) @(posedge clock_50);
    read_expect(enc_base, {11'h000, pos_model}, "enc_position");
    go_idle();
  endtask

  task automatic uart_loop(input logic [31:0] base, input string name);
    logic [7:0]  b1;
    logic [15:0] st;
    int          polls;
    rnd = $random(seed);
    b1 = rnd[7:0];
    write_word(base, {8'h00, b1}, {name, " write"});
    read_expect(base + 32'd2, 16'h0001, {name, " tx_busy"});
    // Ignored while the transmitter is busy
    write_word(base, {8'h00, ~b1}, {name, " busy write"});
    go_idle();
    polls = 0;
    st = 16'h0000;
    while (!st[1] && polls < 100) begin
      read_value(base + 32'd2, st);
      polls = polls + 1;
    end
    if (!st[1]) begin
      errors = errors + 1;
      $display("%s: no byte was received within the polling limit", name);
    end
    read_expect(base, {8'h00, b1}, {name, " rx data"});
    go_idle();
    read_value(base + 32'd2, st);
    check_value({name, " rx_valid cleared"}, 16'h0000, {15'h0000, st[1]});
    // Long enough for a second frame to arrive if one was sent
    repeat (12 * 8) @(posedge clock_50);
    read_expect(base + 32'd2, 16'h0000, {name, " single byte"});
    go_idle();
  endtask

  always @(posedge clock_50) begin
    chk_a <= cur_chk;
    exp_a <= cur_exp;
    name_a <= cur_name;
    if (rst) last_ref <= 16'h0000;
    else if (bus_req.valid && bus_req.write) last_ref <= bus_req.wdata;
  end

  always @(negedge clock_50) begin
    if (checking) begin
      if (chk_a && rdata !== exp_a) begin
        errors = errors + 1;
        $display("[ERROR] %s: expected %h, actual %h", name_a, exp_a, rdata);
      end
      if ({hex3, hex2, hex1, hex0} !== segs_of(last_ref)) begin
        errors = errors + 1;
        $display("[ERROR] hex display: expected %h, actual %h", segs_of(last_ref),
                 {hex3, hex2, hex1, hex0});
      end
    end
  end

  initial begin
    #(watchdog_cycles * 40);
    $display("Timeout: the run did not finish in the time allowed");
    $display("Verification failed");
    $finish;
  end

  initial begin
    seed = 32'h92aa;
    errors = 0;
    checking = 1'b0;
    rst = 1'b1;
    bus_req = '0;
    quad = 2'b00;
    pb = 1'b0;
    rnd = $random(seed);
    sw = rnd[9:0];
    cur_chk = 1'b1;
    cur_exp = 16'h0000;
    cur_name = "idle";
    q_model = 2'b00;
    pos_model = 5'd0;
    repeat (8) @(posedge clock_50);
    rst <= 1'b0;
    checking <= 1'b1;
    @(negedge clock_50);
    check_value("reset rgb", 16'h0000, {13'h0000, rgb});
    check_value("reset serial0 tx", 16'h0001, {15'h0000, serial0_tx});
    check_value("reset serial1 tx", 16'h0001, {15'h0000, serial1_tx});

    // Known contents for the first 64 words
    for (int i = 0; i < 64; i++) begin
      word = {i[7:0] ^ 8'ha5, i[7:0]};
      ram_model[i] = word;
      write_word(32'(i * 2), word, "ram fill");
    end
    for (int n = 0; n < 64; n++) begin
      rnd = $random(seed);
      idx = rnd[5:0];
      other = rnd[13:8];
      ram_model[idx] = ram_merge(ram_model[idx], rnd[6], rnd[7], rnd[31:16]);
      drive_req(1'b1, rnd[6], {25'h0, idx, rnd[6] & rnd[7]}, rnd[31:16], 1'b1, 16'h0000,
                "ram write");
      read_expect({25'h0, idx, 1'b0}, ram_model[idx], "ram read back");
      read_expect({25'h0, other, 1'b0}, ram_model[other], "ram read other");
    end
    go_idle();

    read_expect(32'h0010_0040, 16'h0000, "unmapped io");
    read_expect(32'h0000_0800, 16'h0000, "unmapped above ram");
    read_expect(32'h8000_0000, 16'h0000, "unmapped high");
    read_expect(switch_addr, {6'h00, sw}, "switch");
    go_idle();

    uart_loop(serial0_base, "serial0");
    uart_loop(serial1_base, "serial1");

    read_expect(enc_base, 16'h0000, "enc reset position");
    go_idle();
    // Down from 0 wraps to 23
    quad_step(1'b0);
    quad_step(1'b0);
    for (int n = 0; n < 30; n++) begin
      rnd = $random(seed);
      quad_step(rnd[0]);
    end
    write_word(enc_base, 16'd22, "enc reload");
    go_idle();
    pos_model = 5'd22;
    read_expect(enc_base, 16'd22, "enc reloaded position");
    go_idle();
    // Up from 23 wraps to 0
    repeat (3) quad_step(1'b1);

    @(posedge clock_50);
    pb <= 1'b1;
    repeat (4) @(posedge clock_50);
    read_expect(enc_base + 32'd2, 16'h0001, "enc_button pressed");
    go_idle();
    pb <= 1'b0;
    repeat (4) @(posedge clock_50);
    read_expect(enc_base + 32'd2, 16'h0000, "enc_button released");
    go_idle();

    rnd = $random(seed);
    write_word(enc_base + 32'd4, rnd[15:0], "enc_color");
    read_expect(enc_base + 32'd4, {13'h0000, rnd[2:0]}, "enc_color read");
    go_idle();
    @(negedge clock_50);
    check_value("rgb output", {13'h0000, rnd[2:0]}, {13'h0000, rgb});

    go_idle();
    repeat (2) @(posedge clock_50);
    @(negedge clock_50);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tests/tb_clock.sv */
module tb_clock (
  output logic clock_50
);

  initial clock_50 = 1'b0;

  // 40 time units per period
  always #20 clock_50 = ~clock_50;

endmodule

/* rtl/soc.sv */
module soc
  import soc_pkg::*;
#(
  parameter int clks_per_bit = 434,
  parameter int ram_words = 1024
) (
  input  logic              clock_50,
  input  logic              rst,
  input  bus_req_t          bus_req,
  input  logic [9:0]        sw,
  input  logic [1:0]        quad,
  input  logic              pb,
  input  logic              serial0_rx,
  input  logic              serial1_rx,
  output logic [data_w-1:0] rdata,
  output logic [2:0]        rgb,
  output logic              serial0_tx,
  output logic              serial1_tx,
  output logic [6:0]        hex0,
  output logic [6:0]        hex1,
  output logic [6:0]        hex2,
  output logic [6:0]        hex3
);

  region_t           region;
  region_t           region_q;
  logic [9:0]        sw_q;
  logic [data_w-1:0] last_word;
  logic [data_w-1:0] ram_data;
  logic [data_w-1:0] enc_data;
  logic [data_w-1:0] serial0_data;
  logic [data_w-1:0] serial1_data;
  logic [data_w-1:0] sw_data;

  mem_select memmap0 (.addr(bus_req.addr), .region(region));

  // Region and switches captured with the request, used one cycle later
  always_ff @(posedge clock_50) begin
    sw_q <= sw;
    if (rst) begin
      region_q <= region_none;
      last_word <= '0;
    end else begin
      region_q <= (bus_req.valid && !bus_req.write) ? region : region_none;
      if (bus_req.valid && bus_req.write) last_word <= bus_req.wdata;
    end
  end

  assign sw_data = (region_q == region_switch) ? {6'h00, sw_q} : '0;

  // Unselected slaves return zero, so OR is enough
  assign rdata = ram_data | enc_data | serial0_data | serial1_data | sw_data;

  word_ram #(.ram_words(ram_words)) ram0 (
    .clock_50(clock_50),
    .sel(bus_req.valid && region == region_sram),
    .bus_req(bus_req),
    .rdata(ram_data)
  );

  rgb_enc io0 (
    .clock_50(clock_50),
    .rst(rst),
    .sel(bus_req.valid && region == region_encoder),
    .bus_req(bus_req),
    .quad(quad),
    .pb(pb),
    .rdata(enc_data),
    .rgb(rgb)
  );

  uart #(.clks_per_bit(clks_per_bit)) uart0 (
    .clock_50(clock_50),
    .rst(rst),
    .sel(bus_req.valid && region == region_serial0),
    .bus_req(bus_req),
    .rx(serial0_rx),
    .rdata(serial0_data),
    .tx(serial0_tx)
  );

  uart #(.clks_per_bit(clks_per_bit)) uart1 (
    .clock_50(clock_50),
    .rst(rst),
    .sel(bus_req.valid && region == region_serial1),
    .bus_req(bus_req),
    .rx(serial1_rx),
    .rdata(serial1_data),
    .tx(serial1_tx)
  );

  // Most significant nibble on hex3
  hexdisp d3 (.digit(last_word[15:12]), .seg(hex3));
  hexdisp d2 (.digit(last_word[11:8]), .seg(hex2));
  hexdisp d1 (.digit(last_word[7:4]), .seg(hex1));
  hexdisp d0 (.digit(last_word[3:0]), .seg(hex0));

endmodule

/* rtl/hexdisp.sv */
module hexdisp (
  input  logic [3:0] digit,
  output logic [6:0] seg
);

  // Active low, bit 0 is segment a
  always_comb begin
    case (digit)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b0000011;
      4'hc: seg = 7'b1000110;
      4'hd: seg = 7'b0100001;
      4'he: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
  end

endmodule

/* rtl/rgb_enc.sv */
module rgb_enc
  import soc_pkg::*;
(
  input  logic              clock_50,
  input  logic              rst,
  input  logic              sel,
  input  bus_req_t          bus_req,
  input  logic [1:0]        quad,
  input  logic              pb,
  output logic [data_w-1:0] rdata,
  output logic [2:0]        rgb
);

  enc_reg_t   reg_sel;
  logic       wr;
  logic       rd;
  logic [1:0] quad_s1;
  logic [1:0] quad_s2;
  logic [1:0] quad_prev;
  logic [1:0] pb_s;
  logic       step_up;
  logic       step_dn;
  logic [4:0] position;
  logic [2:0] rgb_q;

  assign reg_sel = enc_reg_t'(bus_req.addr[2:1]);
  assign wr = sel && bus_req.write;
  assign rd = sel && !bus_req.write;
  assign rgb = rgb_q;

  // Gray order 00 01 11 10 counts up
  always_comb begin
    step_up = 1'b0;
    step_dn = 1'b0;
    case ({quad_prev, quad_s2})
      4'b0001, 4'b0111, 4'b1110, 4'b1000: step_up = 1'b1;
      4'b0010, 4'b1011, 4'b1101, 4'b0100: step_dn = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clock_50) begin
    if (rst) begin
      quad_s1 <= '0;
      quad_s2 <= '0;
      quad_prev <= '0;
      pb_s <= '0;
      position <= '0;
      rgb_q <= '0;
      rdata <= '0;
    end else begin
      quad_s1 <= quad;
      quad_s2 <= quad_s1;
      quad_prev <= quad_s2;
      pb_s <= {pb_s[0], pb};
      if (wr && reg_sel == enc_position && bus_req.wdata < 16'd24) begin
        position <= bus_req.wdata[4:0];
      end else if (step_up) begin
        position <= (position == 5'd23) ? 5'd0 : position + 1'b1;
      end else if (step_dn) begin
        position <= (position == 5'd0) ? 5'd23 : position - 1'b1;
      end
      if (wr && reg_sel == enc_color) rgb_q <= bus_req.wdata[2:0];
      rdata <= '0;
      if (rd) begin
        case (reg_sel)
          enc_position: rdata <= {11'h000, position};
          enc_button: rdata <= {15'h0000, pb_s[1]};
          enc_color: rdata <= {13'h0000, rgb_q};
          default: rdata <= '0;
        endcase
      end
    end
  end

endmodule

/* rtl/uart.sv */
module uart
  import soc_pkg::*;
#(
  parameter int clks_per_bit = 434
) (
  input  logic              clock_50,
  input  logic              rst,
  input  logic              sel,
  input  bus_req_t          bus_req,
  input  logic              rx,
  output logic [data_w-1:0] rdata,
  output logic              tx
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_end = cnt_w'(clks_per_bit / 2 - 1);

  uart_reg_t   reg_sel;
  logic        wr;
  logic        rd;
  logic        tx_busy;
  uart_state_t tx_state;
  logic [cnt_w-1:0] tx_cnt;
  logic [2:0]  tx_bit;
  logic [7:0]  tx_shift;
  uart_state_t rx_state;
  logic [cnt_w-1:0] rx_cnt;
  logic [2:0]  rx_bit;
  logic [7:0]  rx_shift;
  logic [1:0]  rx_sync;
  logic [7:0]  rx_byte;
  logic        rx_valid;

  assign reg_sel = uart_reg_t'(bus_req.addr[3:1]);
  assign wr = sel && bus_req.write;
  assign rd = sel && !bus_req.write;
  assign tx_busy = (tx_state != st_idle);

  // Line stays high outside a frame
  assign tx = (tx_state == st_start) ? 1'b0 :
              (tx_state == st_data) ? tx_shift[0] : 1'b1;

  always_ff @(posedge clock_50) begin
    if (rst) begin
      tx_state <= st_idle;
      tx_cnt <= '0;
      tx_bit <= '0;
    end else begin
      case (tx_state)
        st_idle: begin
          // Writes while busy never reach this branch
          if (wr && reg_sel == uart_data) begin
            tx_shift <= bus_req.wdata[7:0];
            tx_cnt <= '0;
            tx_state <= st_start;
          end
        end
        st_start: begin
          tx_cnt <= tx_cnt + 1'b1;
          if (tx_cnt == bit_end) begin
            tx_cnt <= '0;
            tx_bit <= '0;
            tx_state <= st_data;
          end
        end
        st_data: begin
          tx_cnt <= tx_cnt + 1'b1;
          if (tx_cnt == bit_end) begin
            tx_cnt <= '0;
            tx_shift <= tx_shift >> 1;
            tx_bit <= tx_bit + 1'b1;
            if (tx_bit == 3'd7) tx_state <= st_stop;
          end
        end
        default: begin
          tx_cnt <= tx_cnt + 1'b1;
          if (tx_cnt == bit_end) tx_state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock_50) begin
    if (rst) begin
      rx_sync <= 2'b11;
      rx_state <= st_idle;
      rx_cnt <= '0;
      rx_bit <= '0;
      rx_valid <= 1'b0;
      rdata <= '0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rdata <= '0;
      if (rd && reg_sel == uart_data) begin
        rdata <= {8'h00, rx_byte};
        rx_valid <= 1'b0;
      end else if (rd && reg_sel == uart_status) begin
        rdata <= {14'h0000, rx_valid, tx_busy};
      end
      case (rx_state)
        st_idle: begin
          rx_cnt <= '0;
          if (!rx_sync[1]) rx_state <= st_start;
        end
        st_start: begin
          // Confirm the start bit at its middle
          rx_cnt <= rx_cnt + 1'b1;
          if (rx_cnt == half_end) begin
            rx_cnt <= '0;
            rx_bit <= '0;
            rx_state <= rx_sync[1] ? st_idle : st_data;
          end
        end
        st_data: begin
          rx_cnt <= rx_cnt + 1'b1;
          if (rx_cnt == bit_end) begin
            rx_cnt <= '0;
            rx_shift <= {rx_sync[1], rx_shift[7:1]};
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) rx_state <= st_stop;
          end
        end
        default: begin
          rx_cnt <= rx_cnt + 1'b1;
          if (rx_cnt == bit_end) begin
            rx_state <= st_idle;
            // New byte wins over an unread one and over a clearing read
            if (rx_sync[1]) begin
              rx_byte <= rx_shift;
              rx_valid <= 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

/* rtl/word_ram.sv */
module word_ram
  import soc_pkg::*;
#(
  parameter int ram_words = 1024
) (
  input  logic              clock_50,
  input  logic              sel,
  input  bus_req_t          bus_req,
  output logic [data_w-1:0] rdata
);

  localparam int idx_w = $clog2(ram_words);

  logic [data_w-1:0] mem [ram_words];
  logic [idx_w-1:0]  idx;
  logic              wr_lo;
  logic              wr_hi;

  // Byte address, word memory
  assign idx = bus_req.addr[idx_w:1];

  // A byte write touches only the lane picked by addr bit 0
  assign wr_lo = sel && bus_req.write && !(bus_req.bytectl && bus_req.addr[0]);
  assign wr_hi = sel && bus_req.write && !(bus_req.bytectl && !bus_req.addr[0]);

  always_ff @(posedge clock_50) begin
    if (wr_lo) begin
      mem[idx][7:0] <= bus_req.wdata[7:0];
    end
    if (wr_hi) begin
      mem[idx][15:8] <= bus_req.wdata[15:8];
    end
    rdata <= (sel && !bus_req.write) ? mem[idx] : '0;
  end

endmodule

/* rtl/mem_select.sv */
module mem_select
  import soc_pkg::*;
(
  input  logic [addr_w-1:0] addr,
  output region_t           region
);

  logic in_sram;
  logic in_io;

  // 2 KB of word RAM at the bottom of the map
  assign in_sram = (addr[addr_w-1:11] == '0);

  // Peripheral page at 0x0010_0000, 16 bytes per slave
  assign in_io = (addr[addr_w-1:6] == 26'h0004000);

  always_comb begin
    region = region_none;
    if (in_sram) begin
      region = region_sram;
    end else if (in_io) begin
      case (addr[5:4])
        2'd0: region = region_encoder;
        2'd1: region = region_serial0;
        2'd2: region = region_serial1;
        2'd3: region = region_switch;
        default: region = region_none;
      endcase
    end
  end

endmodule

/* rtl/soc_pkg.sv */
package soc_pkg;

  localparam int data_w = 16;
  localparam int addr_w = 32;

  // One bus request from the master, sampled at the rising edge
  typedef struct packed {
    logic              valid;
    logic              write;
    logic              bytectl;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } bus_req_t;

  // Slave regions of the memory map
  typedef enum logic [2:0] {
    region_none,
    region_sram,
    region_encoder,
    region_serial0,
    region_serial1,
    region_switch
  } region_t;

  // UART registers, addr bits 3 to 1
  typedef enum logic [2:0] {
    uart_data   = 3'd0,
    uart_status = 3'd1
  } uart_reg_t;

  // Encoder registers, addr bits 2 to 1
  typedef enum logic [1:0] {
    enc_position = 2'd0,
    enc_button   = 2'd1,
    enc_color    = 2'd2
  } enc_reg_t;

  // Serial transmit and receive states
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } uart_state_t;

endpackage
